/* compile.f */
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_pipe_reg.sv
rv_hazard.sv
rv_stage_seq.sv
rv_event_cnt.sv
rv_ctrl_top.sv
tb_rv_ctrl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_ctrl -f compile.f
./obj_dir/Vtb_rv_ctrl > sim.log
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation finished without errors"
else
    echo "simulation reported errors, see sim.log"
    exit 1
fi

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    typedef logic [1:0] bp_sel_t;

    localparam bp_sel_t BP_DIRECT   = 2'd0;         // operand straight from the register file
    localparam bp_sel_t BP_MEMORY   = 2'd1;
    localparam bp_sel_t BP_WRITE    = 2'd2;
    localparam bp_sel_t BP_WRITE_BK = 2'd3;

    typedef logic [2:0] stage_t;

    localparam stage_t STAGE_FETCH   = 3'h1;
    localparam stage_t STAGE_DECODE  = 3'h2;
    localparam stage_t STAGE_EXECUTE = 3'h3;
    localparam stage_t STAGE_MEMORY  = 3'h4;
    localparam stage_t STAGE_WRITE   = 3'h5;

    typedef struct packed {
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
        rv_isa_pkg::res_src_t res_src;
    } dec_meta_t;

    // only the destination matters once the instruction has left execute
    typedef struct packed {
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
    } wb_meta_t;

    localparam int CNT_W = 16;

endpackage

/* rv_ctrl_stim.txt */
# test rst_n staged rs1 rs2 rd reg_wr res_src inv pc_sel, then expected: bp_rs1 bp_rs2
# pre_stall fetch_stall decode_stall decode_flush exec_flush stage stall_cnt flush_cnt (hex)
# rows with rst_n 0 are reset cycles; tests 1 bypass, 2 load-use, 3 branch, 4 staged, 5 counts
1 0 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 0 0000 0000
1 1 0 00 00 05 1 0 0 0   0 0 0 0 0 0 0 4 0000 0000
1 1 0 00 00 05 1 0 0 0   0 0 0 0 0 0 0 5 0000 0000
1 1 0 00 00 05 1 0 0 0   0 0 0 0 0 0 0 1 0000 0000
1 1 0 05 00 06 1 0 0 0   0 0 0 0 0 0 0 2 0000 0000
1 1 0 05 05 00 0 0 0 0   1 0 0 0 0 0 0 3 0000 0000
1 1 0 05 06 00 0 0 0 0   2 2 0 0 0 0 0 4 0000 0000
1 1 0 06 05 00 0 0 0 0   3 2 0 0 0 0 0 5 0000 0000
1 1 0 00 00 00 1 0 0 0   3 0 0 0 0 0 0 1 0000 0000
1 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 2 0000 0000
1 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 3 0000 0000
2 0 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 0 0000 0000
2 1 0 00 00 07 1 1 0 0   0 0 0 0 0 0 0 4 0000 0000
2 1 0 07 00 08 1 0 0 0   0 0 0 1 1 0 1 5 0000 0000
2 1 0 07 00 08 1 0 0 0   0 0 0 0 0 0 0 1 0001 0001
2 1 0 00 00 00 0 0 0 0   2 0 0 0 0 0 0 2 0001 0001
2 1 0 00 00 09 1 2 0 0   0 0 0 0 0 0 0 3 0001 0001
2 1 0 00 09 0a 1 0 0 0   0 0 0 1 1 0 1 4 0001 0001
2 1 0 00 09 0a 1 0 0 0   0 0 0 0 0 0 0 5 0002 0002
2 1 0 00 00 00 0 0 0 0   0 2 0 0 0 0 0 1 0002 0002
2 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 2 0002 0002
3 0 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 0 0000 0000
3 1 0 00 00 0b 1 0 0 0   0 0 0 0 0 0 0 4 0000 0000
3 1 0 0b 00 0c 1 0 0 1   0 0 0 0 0 1 1 5 0000 0000
3 1 0 0c 0b 00 0 0 0 0   0 0 0 0 0 0 0 1 0000 0001
3 1 0 00 00 00 0 0 0 0   0 2 0 0 0 0 0 2 0000 0001
3 1 0 00 00 00 0 0 0 1   0 0 0 0 0 1 1 3 0000 0001
3 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 4 0000 0002
4 0 1 00 00 00 0 0 0 0   0 0 0 0 0 0 0 0 0000 0000
4 1 1 00 00 03 1 1 0 0   0 0 1 1 0 1 0 4 0000 0000
4 1 1 03 00 00 0 0 0 0   0 0 0 1 0 1 0 5 0001 0000
4 1 1 00 00 00 0 0 0 1   0 0 1 0 0 0 0 1 0002 0000
4 1 1 00 00 00 0 0 1 0   0 0 1 1 0 1 0 2 0002 0000
4 1 1 00 00 00 0 0 1 0   0 0 1 1 0 1 0 2 0003 0000
4 1 1 00 00 00 0 0 0 0   0 0 1 1 0 1 0 2 0004 0000
4 1 1 00 00 00 0 0 0 0   0 0 1 1 0 1 0 3 0005 0000
4 1 1 00 00 00 0 0 0 0   0 0 1 1 0 1 0 4 0006 0000
4 1 1 00 00 00 0 0 0 0   0 0 0 1 0 1 0 5 0007 0000
4 1 1 00 00 00 0 0 0 0   0 0 1 0 0 0 0 1 0008 0000
5 0 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 0 0000 0000
5 1 0 00 00 00 0 0 0 1   0 0 0 0 0 1 1 4 0000 0000
5 1 0 00 00 00 0 0 0 1   0 0 0 0 0 1 1 5 0000 0001
5 1 0 00 00 04 1 1 0 0   0 0 0 0 0 0 0 1 0000 0002
5 1 0 04 04 00 0 0 0 0   0 0 0 1 1 0 1 2 0000 0002
5 1 0 04 04 00 0 0 0 0   0 0 0 0 0 0 0 3 0001 0003
5 1 0 00 00 04 1 2 0 0   2 2 0 0 0 0 0 4 0001 0003
5 1 0 00 04 00 0 0 0 1   0 0 0 1 1 1 1 5 0001 0003
5 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 1 0002 0004
5 1 0 00 00 00 0 0 0 0   0 0 0 0 0 0 0 2 0002 0004

/* rv_ctrl_top.sv */
module rv_ctrl_top
(
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          i_staged_mode,
    input  rv_isa_pkg::reg_idx_t          i_decode_rs1,
    input  rv_isa_pkg::reg_idx_t          i_decode_rs2,
    input  rv_isa_pkg::reg_idx_t          i_decode_rd,
    input  logic                          i_decode_reg_write,
    input  rv_isa_pkg::res_src_t          i_decode_res_src,
    input  logic                          i_decode_inv_instr,
    input  logic                          i_exec_pc_sel,
    output rv_ctrl_pkg::bp_sel_t          o_exec_bp_rs1,
    output rv_ctrl_pkg::bp_sel_t          o_exec_bp_rs2,
    output logic                          o_fetch_pre_stall,
    output logic                          o_fetch_stall,
    output logic                          o_decode_stall,
    output logic                          o_decode_flush,
    output logic                          o_exec_flush,
    output rv_ctrl_pkg::stage_t           o_stage,
    output logic [rv_ctrl_pkg::CNT_W-1:0] o_stall_count,
    output logic [rv_ctrl_pkg::CNT_W-1:0] o_flush_count
);

    import rv_ctrl_pkg::*;

    dec_meta_t w_decode_meta;
    dec_meta_t r_exec_meta;
    wb_meta_t  w_memory_d;
    wb_meta_t  r_memory_meta;
    wb_meta_t  r_write_meta;
    wb_meta_t  r_write_back_meta;

    bp_sel_t   w_haz_bp_rs1;
    bp_sel_t   w_haz_bp_rs2;
    logic      w_load_stall;
    logic      w_haz_decode_flush;
    logic      w_haz_exec_flush;

    logic      w_seq_pre_stall;
    logic      w_seq_fetch_stall;
    logic      w_seq_decode_flush;

    assign w_decode_meta = '{
        rs1:       i_decode_rs1,
        rs2:       i_decode_rs2,
        rd:        i_decode_rd,
        reg_write: i_decode_reg_write,
        res_src:   i_decode_res_src
    };

    // a flushed execute slot becomes a bubble for the next stages
    rv_pipe_reg #(.payload_t(dec_meta_t)) u_exec_reg
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clear   (o_exec_flush),
        .i_d       (w_decode_meta),
        .o_q       (r_exec_meta)
    );

    assign w_memory_d = '{rd: r_exec_meta.rd, reg_write: r_exec_meta.reg_write};

    rv_pipe_reg #(.payload_t(wb_meta_t)) u_memory_reg
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clear   (1'b0),
        .i_d       (w_memory_d),
        .o_q       (r_memory_meta)
    );

    rv_pipe_reg #(.payload_t(wb_meta_t)) u_write_reg
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clear   (1'b0),
        .i_d       (r_memory_meta),
        .o_q       (r_write_meta)
    );

    rv_pipe_reg #(.payload_t(wb_meta_t)) u_write_back_reg
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clear   (1'b0),
        .i_d       (r_write_meta),
        .o_q       (r_write_back_meta)
    );

    rv_hazard u_hazard
    (
        .i_decode_rs1      (i_decode_rs1),
        .i_decode_rs2      (i_decode_rs2),
        .i_exec_meta       (r_exec_meta),
        .i_exec_pc_sel     (i_exec_pc_sel),
        .i_memory_meta     (r_memory_meta),
        .i_write_meta      (r_write_meta),
        .i_write_back_meta (r_write_back_meta),
        .o_exec_bp_rs1     (w_haz_bp_rs1),
        .o_exec_bp_rs2     (w_haz_bp_rs2),
        .o_load_stall      (w_load_stall),
        .o_decode_flush    (w_haz_decode_flush),
        .o_exec_flush      (w_haz_exec_flush)
    );

    rv_stage_seq u_stage_seq
    (
        .i_clk              (i_clk),
        .i_reset_n          (i_reset_n),
        .i_decode_inv_instr (i_decode_inv_instr),
        .o_stage            (o_stage),
        .o_fetch_pre_stall  (w_seq_pre_stall),
        .o_fetch_stall      (w_seq_fetch_stall),
        .o_decode_flush     (w_seq_decode_flush)
    );

    // with one instruction in flight there is nothing to bypass or squash
    always_comb
    begin
        if (i_staged_mode)
        begin
            o_exec_bp_rs1     = BP_DIRECT;
            o_exec_bp_rs2     = BP_DIRECT;
            o_fetch_pre_stall = w_seq_pre_stall;
            o_fetch_stall     = w_seq_fetch_stall;
            o_decode_stall    = 1'b0;
            o_decode_flush    = w_seq_decode_flush;
            o_exec_flush      = 1'b0;
        end
        else
        begin
            o_exec_bp_rs1     = w_haz_bp_rs1;
            o_exec_bp_rs2     = w_haz_bp_rs2;
            o_fetch_pre_stall = 1'b0;
            o_fetch_stall     = w_load_stall;
            o_decode_stall    = w_load_stall;
            o_decode_flush    = w_haz_decode_flush;
            o_exec_flush      = w_haz_exec_flush;
        end
    end

    rv_event_cnt u_event_cnt
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_stall       (o_fetch_stall),
        .i_flush       (o_exec_flush),
        .o_stall_count (o_stall_count),
        .o_flush_count (o_flush_count)
    );

endmodule

/* rv_event_cnt.sv */
module rv_event_cnt
(
    input  logic                          i_clk,
    input  logic                          i_reset_n,
    input  logic                          i_stall,
    input  logic                          i_flush,
    output logic [rv_ctrl_pkg::CNT_W-1:0] o_stall_count,
    output logic [rv_ctrl_pkg::CNT_W-1:0] o_flush_count
);

    import rv_ctrl_pkg::*;

    localparam int NUM_EV = 2;

    logic [NUM_EV-1:0] w_events;
    logic [CNT_W-1:0]  r_count [NUM_EV];

    assign w_events = {i_flush, i_stall};           // slot 0 stalls, slot 1 flushes

    // each count sticks at all ones rather than wrapping
    always_ff @(posedge i_clk)
    begin
        for (int k = 0; k < NUM_EV; k++)
        begin
            if (!i_reset_n)
            begin
                r_count[k] <= '0;
            end
            else if (w_events[k] && (r_count[k] != '1))
            begin
                r_count[k] <= r_count[k] + 1'b1;
            end
        end
    end

    assign o_stall_count = r_count[0];
    assign o_flush_count = r_count[1];

endmodule

/* rv_hazard.sv */
module rv_hazard
(
    input  rv_isa_pkg::reg_idx_t  i_decode_rs1,
    input  rv_isa_pkg::reg_idx_t  i_decode_rs2,
    input  rv_ctrl_pkg::dec_meta_t i_exec_meta,
    input  logic                  i_exec_pc_sel,
    input  rv_ctrl_pkg::wb_meta_t i_memory_meta,
    input  rv_ctrl_pkg::wb_meta_t i_write_meta,
    input  rv_ctrl_pkg::wb_meta_t i_write_back_meta,
    output rv_ctrl_pkg::bp_sel_t  o_exec_bp_rs1,
    output rv_ctrl_pkg::bp_sel_t  o_exec_bp_rs2,
    output logic                  o_load_stall,
    output logic                  o_decode_flush,
    output logic                  o_exec_flush
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic w_exec_is_load;
    logic w_load_stall;

    // nearest producer wins, a later stage only counts when the earlier ones miss
    function automatic bp_sel_t bp_select
    (
        input reg_idx_t rs,
        input wb_meta_t mem,
        input wb_meta_t wr,
        input wb_meta_t wb
    );
        bp_sel_t sel;
        sel = BP_DIRECT;
        if (rs != REG_ZERO)
        begin
            if (mem.reg_write && (mem.rd == rs))
            begin
                sel = BP_MEMORY;
            end
            else if (wr.reg_write && (wr.rd == rs))
            begin
                sel = BP_WRITE;
            end
            else if (wb.reg_write && (wb.rd == rs))
            begin
                sel = BP_WRITE_BK;
            end
        end
        return sel;
    endfunction

    always_comb
    begin
        o_exec_bp_rs1 = bp_select(i_exec_meta.rs1, i_memory_meta, i_write_meta,
                                  i_write_back_meta);
        o_exec_bp_rs2 = bp_select(i_exec_meta.rs2, i_memory_meta, i_write_meta,
                                  i_write_back_meta);
    end

    assign w_exec_is_load = (i_exec_meta.res_src == RES_SRC_MEMORY) ||
                            (i_exec_meta.res_src == RES_SRC_TCM);

    // load data arrives too late to bypass into the very next instruction
    assign w_load_stall = w_exec_is_load &&
                          ((i_decode_rs1 == i_exec_meta.rd) ||
                           (i_decode_rs2 == i_exec_meta.rd));

    assign o_load_stall   = w_load_stall;
    assign o_decode_flush = i_exec_pc_sel;
    assign o_exec_flush   = i_exec_pc_sel || w_load_stall;   // a stall leaves a bubble in execute

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // x0 is hardwired to zero, so it never has a producer in flight
    localparam reg_idx_t REG_ZERO = '0;

    localparam int RES_SRC_W = 2;

    typedef logic [RES_SRC_W-1:0] res_src_t;

    localparam res_src_t RES_SRC_ALU    = 2'd0;
    localparam res_src_t RES_SRC_MEMORY = 2'd1;     // data bus load, result known in memory stage
    localparam res_src_t RES_SRC_TCM    = 2'd2;     // tightly coupled memory load
    localparam res_src_t RES_SRC_PC4    = 2'd3;     // link address for jal and jalr

endpackage

/* rv_pipe_reg.sv */
module rv_pipe_reg
#(
    parameter type payload_t = logic
)
(
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_clear,
    input  payload_t i_d,
    output payload_t o_q
);

    payload_t r_slot;

    // an all-zero slot has reg_write low, so a bubble never claims a register
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_slot <= '0;
        end
        else if (i_clear)
        begin
            r_slot <= '0;                       // squash into a bubble
        end
        else
        begin
            r_slot <= i_d;
        end
    end

    assign o_q = r_slot;

endmodule

/* rv_stage_seq.sv */
module rv_stage_seq
(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_decode_inv_instr,
    output rv_ctrl_pkg::stage_t  o_stage,
    output logic                 o_fetch_pre_stall,
    output logic                 o_fetch_stall,
    output logic                 o_decode_flush
);

    import rv_ctrl_pkg::*;

    stage_t r_stage;
    stage_t w_stage_next;

    // starting in memory lets the first fetch begin two cycles after reset
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_stage <= STAGE_MEMORY;
        end
        else
        begin
            r_stage <= w_stage_next;
        end
    end

    always_comb
    begin
        case (r_stage)
            STAGE_FETCH:
                w_stage_next = STAGE_DECODE;
            STAGE_DECODE:
                w_stage_next = i_decode_inv_instr ? STAGE_DECODE : STAGE_EXECUTE;
            STAGE_EXECUTE:
                w_stage_next = STAGE_MEMORY;
            STAGE_MEMORY:
                w_stage_next = STAGE_WRITE;
            STAGE_WRITE:
                w_stage_next = STAGE_FETCH;
            default:
                w_stage_next = STAGE_FETCH;         // recover from an unused code
        endcase
    end

    assign o_stage = r_stage;

    // fetch is released one cycle early so the next instruction is on its way
    assign o_fetch_pre_stall = !((r_stage == STAGE_WRITE) && (w_stage_next == STAGE_FETCH));
    assign o_fetch_stall     = (r_stage != STAGE_FETCH);
    assign o_decode_flush    = !((r_stage == STAGE_FETCH) && (w_stage_next == STAGE_DECODE));

endmodule

/* tb_rv_ctrl.sv */
module tb_rv_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int MAX_VEC = 256;
    localparam int NUM_COL = 20;

    logic             i_clk;
    logic             i_reset_n;
    logic             i_staged_mode;
    reg_idx_t         i_decode_rs1;
    reg_idx_t         i_decode_rs2;
    reg_idx_t         i_decode_rd;
    logic             i_decode_reg_write;
    res_src_t         i_decode_res_src;
    logic             i_decode_inv_instr;
    logic             i_exec_pc_sel;
    bp_sel_t          o_exec_bp_rs1;
    bp_sel_t          o_exec_bp_rs2;
    logic             o_fetch_pre_stall;
    logic             o_fetch_stall;
    logic             o_decode_stall;
    logic             o_decode_flush;
    logic             o_exec_flush;
    stage_t           o_stage;
    logic [CNT_W-1:0] o_stall_count;
    logic [CNT_W-1:0] o_flush_count;

    logic [31:0] vec [MAX_VEC][NUM_COL];       // one row per cycle, columns as in the file header
    logic [31:0] fld [NUM_COL];
    int          n_vec;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          cur_row;
    logic [31:0] cur_test;
    int          test_rows;
    int          test_errors;
    int          total_errors;
    int          total_checks;

    rv_ctrl_top dut (.*);

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic load_vectors();
        int    fd;
        int    rc;
        int    k;
        string line;
        fd = $fopen("rv_ctrl_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file rv_ctrl_stim.txt");
            total_errors++;
        end
        else
        begin
            while (!$feof(fd) && n_vec < MAX_VEC)
            begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line.getc(0) != "#")
                begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                 fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                                 fld[14], fld[15], fld[16], fld[17], fld[18], fld[19]);
                    if (rc == NUM_COL)
                    begin
                        for (k = 0; k < NUM_COL; k++)
                            vec[n_vec][k] = fld[k];
                        n_vec++;
                    end
                    else
                    begin
                        $display("malformed stimulus line: %s", line);
                        total_errors++;
                    end
                end
            end
            $fclose(fd);
            if (n_vec == 0)
            begin
                $display("no stimulus vectors were read");
                total_errors++;
            end
        end
    endtask

    task automatic drive_vector(input int idx);
        i_reset_n          = vec[idx][1][0];
        i_staged_mode      = vec[idx][2][0];
        i_decode_rs1       = vec[idx][3][4:0];
        i_decode_rs2       = vec[idx][4][4:0];
        i_decode_rd        = vec[idx][5][4:0];
        i_decode_reg_write = vec[idx][6][0];
        i_decode_res_src   = vec[idx][7][1:0];
        i_decode_inv_instr = vec[idx][8][0];
        i_exec_pc_sel      = vec[idx][9][0];
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] test %0d vector %0d: %s expected 0x%0h, got 0x%0h",
                 cur_test, cur_row, name, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_outputs(input int idx);
        total_checks++;
        if (o_exec_bp_rs1 !== vec[idx][10][1:0])
            report_mismatch("o_exec_bp_rs1", vec[idx][10], 32'(o_exec_bp_rs1));
        if (o_exec_bp_rs2 !== vec[idx][11][1:0])
            report_mismatch("o_exec_bp_rs2", vec[idx][11], 32'(o_exec_bp_rs2));
        if (o_fetch_pre_stall !== vec[idx][12][0])
            report_mismatch("o_fetch_pre_stall", vec[idx][12], 32'(o_fetch_pre_stall));
        if (o_fetch_stall !== vec[idx][13][0])
            report_mismatch("o_fetch_stall", vec[idx][13], 32'(o_fetch_stall));
        if (o_decode_stall !== vec[idx][14][0])
            report_mismatch("o_decode_stall", vec[idx][14], 32'(o_decode_stall));
        if (o_decode_flush !== vec[idx][15][0])
            report_mismatch("o_decode_flush", vec[idx][15], 32'(o_decode_flush));
        if (o_exec_flush !== vec[idx][16][0])
            report_mismatch("o_exec_flush", vec[idx][16], 32'(o_exec_flush));
        if (o_stage !== vec[idx][17][2:0])
            report_mismatch("o_stage", vec[idx][17], 32'(o_stage));
        if (o_stall_count !== vec[idx][18][CNT_W-1:0])
            report_mismatch("o_stall_count", vec[idx][18], 32'(o_stall_count));
        if (o_flush_count !== vec[idx][19][CNT_W-1:0])
            report_mismatch("o_flush_count", vec[idx][19], 32'(o_flush_count));
    endtask

    task automatic report_test_end();
        $display("test %0d finished: %0d cycles, %0d errors", cur_test, test_rows, test_errors);
    endtask

    initial
    begin
        int idx;
        i_clk              = 1'b0;
        i_reset_n          = 1'b0;
        i_staged_mode      = 1'b0;
        i_decode_rs1       = '0;
        i_decode_rs2       = '0;
        i_decode_rd        = '0;
        i_decode_reg_write = 1'b0;
        i_decode_res_src   = '0;
        i_decode_inv_instr = 1'b0;
        i_exec_pc_sel      = 1'b0;
        n_vec              = 0;
        cur_test           = '1;
        test_rows          = 0;
        test_errors        = 0;
        total_errors       = 0;
        total_checks       = 0;
        load_vectors();
        cycle_limit = 2 * n_vec + 20;
        repeat (5) @(posedge i_clk);
        for (idx = 0; idx < n_vec; idx++)
        begin
            if (vec[idx][0] != cur_test)
            begin
                if (test_rows > 0)
                    report_test_end();
                cur_test    = vec[idx][0];
                test_rows   = 0;
                test_errors = 0;
            end
            cur_row = idx;
            @(negedge i_clk);
            drive_vector(idx);
            #3;                                 // one ns before the next rising edge
            if (vec[idx][1][0])
                check_outputs(idx);             // outputs during a reset cycle are not compared
            test_rows++;
        end
        if (test_rows > 0)
            report_test_end();
        $display("vectors %0d, checked %0d, errors %0d", n_vec, total_checks, total_errors);
        if (total_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
